// ==== rtl/cu_setup_cfg_pkg.sv ====
package cu_setup_cfg_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int ADDR_W = 32;
    localparam int SIZE_W = 16;

    // Byte address into the descriptor's buffer
    typedef logic [ADDR_W-1:0] addr_t;

    // Number of words to read in one phase
    typedef logic [SIZE_W-1:0] count_t;

    // ----------------------------------------
    // Kernel descriptor
    // ----------------------------------------
    // Upper half sizes the flush phase, lower half the program phase
    typedef struct packed {
        count_t upper;
        count_t lower;
    } size_word_t;

    typedef struct packed {
        logic       valid;
        addr_t      base_ptr;
        size_word_t size_word;
    } kernel_descriptor_t;

    // ----------------------------------------
    // Read engine configuration
    // ----------------------------------------
    typedef enum logic {
        BUF_PROGRAM = 1'b0,
        BUF_FLUSH   = 1'b1
    } buffer_kind_t;

    typedef struct packed {
        addr_t        base_ptr;
        count_t       word_count;
        buffer_kind_t kind;
    } read_config_t;

    // Setup sequencer states
    typedef enum logic [3:0] {
        RESET,
        IDLE,
        REQ_START,
        REQ_BUSY,
        REQ_PAUSE,
        REQ_DONE,
        FLUSH_START,
        FLUSH_BUSY,
        FLUSH_PAUSE,
        FLUSH_DONE
    } setup_state_t;

endpackage : cu_setup_cfg_pkg

// ==== rtl/cu_setup_mem_pkg.sv ====
package cu_setup_mem_pkg;

    // ----------------------------------------
    // Memory side widths
    // ----------------------------------------
    localparam int DATA_W        = 32;
    // One word is four bytes
    localparam int GRANULE_SHIFT = 2;

    typedef enum logic {
        CMD_MEM_READ = 1'b0
    } mem_cmd_t;

    // ----------------------------------------
    // Request and response packets
    // ----------------------------------------
    typedef struct packed {
        cu_setup_cfg_pkg::addr_t        address;
        mem_cmd_t                       cmd;
        cu_setup_cfg_pkg::buffer_kind_t kind;
    } mem_request_payload_t;

    typedef struct packed {
        logic                 valid;
        mem_request_payload_t payload;
    } mem_request_t;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
    } mem_response_t;

    // Request FIFO sizing
    localparam int REQ_FIFO_DEPTH       = 16;
    localparam int REQ_FIFO_PROG_THRESH = 12;

endpackage : cu_setup_mem_pkg

// ==== rtl/cu_setup_request_fifo.sv ====
module cu_setup_request_fifo #(
    parameter int DEPTH       = cu_setup_mem_pkg::REQ_FIFO_DEPTH,
    parameter int PROG_THRESH = cu_setup_mem_pkg::REQ_FIFO_PROG_THRESH
) (
    input  logic                                   ap_clk,
    input  logic                                   areset_cu_setup,
    input  logic                                   push,
    input  cu_setup_mem_pkg::mem_request_payload_t din,
    input  logic                                   pop_ready,
    output cu_setup_mem_pkg::mem_request_t         dout,
    output logic                                   empty,
    output logic                                   prog_full
);
    import cu_setup_mem_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    mem_request_payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] occupancy;
    logic             wr_en;
    logic             pop;

    // Writes into a full buffer are dropped
    assign wr_en     = push & (occupancy != CNT_W'(DEPTH));
    assign pop       = ~empty & pop_ready;
    assign empty     = (occupancy == '0);
    assign prog_full = (occupancy >= CNT_W'(PROG_THRESH));

    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_ptr + PTR_W'(1);
            if (pop)
                rd_ptr <= rd_ptr + PTR_W'(1);
            case ({wr_en, pop})
                2'b10:   occupancy <= occupancy + CNT_W'(1);
                2'b01:   occupancy <= occupancy - CNT_W'(1);
                default: occupancy <= occupancy;
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (wr_en)
            mem[wr_ptr] <= din;
    end

    // Read data shows up the cycle after the pop
    always_ff @(posedge ap_clk) begin
        dout.valid <= pop;
        if (pop)
            dout.payload <= mem[rd_ptr];
        if (areset_cu_setup)
            dout.valid <= 1'b0;
    end

endmodule : cu_setup_request_fifo

// ==== rtl/cu_setup_read_engine.sv ====
module cu_setup_read_engine (
    input  logic                           ap_clk,
    input  logic                           areset_cu_setup,
    input  logic                           start,
    input  cu_setup_cfg_pkg::read_config_t cfg,
    input  logic                           fifo_prog_full,
    output cu_setup_mem_pkg::mem_request_t req_out,
    output logic                           ready,
    output logic                           done
);
    import cu_setup_cfg_pkg::*;
    import cu_setup_mem_pkg::*;

    read_config_t cfg_q;
    logic         busy;
    count_t       word_idx;
    count_t       last_idx;
    logic         issue;
    logic         launch;

    assign ready    = ~busy;
    assign launch   = start & ready;
    assign issue    = busy & ~fifo_prog_full;
    assign last_idx = cfg_q.word_count - count_t'(1);

    // One word per request, stride fixed at one word
    always_comb begin
        req_out.valid           = issue;
        req_out.payload.address = cfg_q.base_ptr + (addr_t'(word_idx) << GRANULE_SHIFT);
        req_out.payload.cmd     = CMD_MEM_READ;
        req_out.payload.kind    = cfg_q.kind;
    end

    // ----------------------------------------
    // Word counter
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            word_idx <= '0;
        end else begin
            done <= 1'b0;
            if (launch) begin
                word_idx <= '0;
                // Empty phase finishes without a request
                busy     <= (cfg.word_count != '0);
                done     <= (cfg.word_count == '0);
            end else if (issue) begin
                word_idx <= word_idx + count_t'(1);
                if (word_idx == last_idx) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (launch)
            cfg_q <= cfg;
    end

endmodule : cu_setup_read_engine

// ==== rtl/cu_setup_sequencer.sv ====
module cu_setup_sequencer (
    input  logic                                 ap_clk,
    input  logic                                 areset_cu_setup,
    input  cu_setup_cfg_pkg::kernel_descriptor_t descriptor,
    input  logic                                 cu_flush,
    input  logic                                 response_valid,
    input  logic                                 engine_ready,
    input  logic                                 engine_done,
    input  logic                                 fifo_prog_full,
    input  logic                                 fifo_empty,
    output logic                                 start,
    output cu_setup_cfg_pkg::read_config_t       cfg,
    output logic                                 done
);
    import cu_setup_cfg_pkg::*;

    setup_state_t state;
    setup_state_t next_state;

    // Descriptor captured when accepted in IDLE
    addr_t      base_ptr_q;
    size_word_t size_q;

    count_t program_count;
    count_t flush_count;
    count_t resp_count;
    logic   resp_zero;
    logic   engine_done_seen;
    logic   phase_done;
    logic   accept;

    // Program phase reads half the lower size field
    assign program_count = size_q.lower >> 1;
    assign flush_count   = size_q.upper;

    assign resp_zero  = (resp_count == '0);
    assign phase_done = (engine_done_seen | engine_done) & resp_zero;
    assign accept     = (state == IDLE) & descriptor.valid & engine_ready;

    // ----------------------------------------
    // Next state
    // ----------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            RESET:       next_state = IDLE;
            IDLE:        if (accept) next_state = REQ_START;
            REQ_START:   next_state = REQ_BUSY;
            REQ_BUSY: begin
                if (phase_done)
                    next_state = REQ_DONE;
                else if (fifo_prog_full)
                    next_state = REQ_PAUSE;
            end
            REQ_PAUSE:   if (!fifo_prog_full) next_state = REQ_BUSY;
            // Flush request only honoured once the program phase is over
            REQ_DONE:    if (cu_flush && engine_ready) next_state = FLUSH_START;
            FLUSH_START: next_state = FLUSH_BUSY;
            FLUSH_BUSY: begin
                if (phase_done)
                    next_state = FLUSH_DONE;
                else if (fifo_prog_full)
                    next_state = FLUSH_PAUSE;
            end
            FLUSH_PAUSE: if (!fifo_prog_full) next_state = FLUSH_BUSY;
            FLUSH_DONE:  next_state = FLUSH_DONE;
            default:     next_state = RESET;
        endcase
    end

    // ----------------------------------------
    // Control registers
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            state            <= RESET;
            start            <= 1'b0;
            engine_done_seen <= 1'b0;
            resp_count       <= '0;
            done             <= 1'b0;
        end else begin
            state <= next_state;
            start <= (state == REQ_START) | (state == FLUSH_START);

            // Engine done is a pulse, keep it until the phase closes
            if ((state == REQ_START) || (state == FLUSH_START))
                engine_done_seen <= 1'b0;
            else if (engine_done)
                engine_done_seen <= 1'b1;

            // Outstanding response count
            if (state == REQ_START)
                resp_count <= program_count;
            else if (state == FLUSH_START)
                resp_count <= flush_count;
            else if (response_valid && !resp_zero)
                resp_count <= resp_count - count_t'(1);

            done <= done | ((state == FLUSH_DONE) & fifo_empty & resp_zero);
        end
    end

    // ----------------------------------------
    // Descriptor capture and configuration
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (accept) begin
            base_ptr_q <= descriptor.base_ptr;
            size_q     <= descriptor.size_word;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (state == REQ_START) begin
            cfg.base_ptr   <= base_ptr_q;
            cfg.word_count <= program_count;
            cfg.kind       <= BUF_PROGRAM;
        end else if (state == FLUSH_START) begin
            cfg.base_ptr   <= base_ptr_q;
            cfg.word_count <= flush_count;
            cfg.kind       <= BUF_FLUSH;
        end
    end

endmodule : cu_setup_sequencer

// ==== rtl/cu_setup.sv ====
module cu_setup (
    input  logic                                 ap_clk,
    input  logic                                 areset_cu_setup,
    input  cu_setup_cfg_pkg::kernel_descriptor_t descriptor,
    input  logic                                 cu_flush,
    input  cu_setup_mem_pkg::mem_response_t      response,
    input  logic                                 request_ready,
    output cu_setup_mem_pkg::mem_request_t       request,
    output logic                                 done_out
);
    import cu_setup_cfg_pkg::*;
    import cu_setup_mem_pkg::*;

    kernel_descriptor_t descriptor_reg;
    logic               cu_flush_reg;
    logic               response_valid_reg;
    logic               request_ready_reg;

    logic         engine_start;
    read_config_t engine_cfg;
    mem_request_t engine_req;
    logic         engine_ready;
    logic         engine_done;

    logic         fifo_empty;
    logic         fifo_prog_full;
    mem_request_t fifo_dout;
    logic         setup_done;

    // ----------------------------------------
    // Input and output registers
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        descriptor_reg <= descriptor;
        request        <= fifo_dout;
        if (areset_cu_setup) begin
            descriptor_reg.valid <= 1'b0;
            request.valid        <= 1'b0;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            cu_flush_reg       <= 1'b0;
            response_valid_reg <= 1'b0;
            request_ready_reg  <= 1'b0;
            done_out           <= 1'b0;
        end else begin
            cu_flush_reg       <= cu_flush;
            response_valid_reg <= response.valid;
            request_ready_reg  <= request_ready;
            done_out           <= setup_done;
        end
    end

    cu_setup_sequencer u_sequencer (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .descriptor      (descriptor_reg),
        .cu_flush        (cu_flush_reg),
        .response_valid  (response_valid_reg),
        .engine_ready    (engine_ready),
        .engine_done     (engine_done),
        .fifo_prog_full  (fifo_prog_full),
        .fifo_empty      (fifo_empty),
        .start           (engine_start),
        .cfg             (engine_cfg),
        .done            (setup_done)
    );

    cu_setup_read_engine u_read_engine (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .start           (engine_start),
        .cfg             (engine_cfg),
        .fifo_prog_full  (fifo_prog_full),
        .req_out         (engine_req),
        .ready           (engine_ready),
        .done            (engine_done)
    );

    cu_setup_request_fifo #(
        .DEPTH       (REQ_FIFO_DEPTH),
        .PROG_THRESH (REQ_FIFO_PROG_THRESH)
    ) u_request_fifo (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .push            (engine_req.valid),
        .din             (engine_req.payload),
        .pop_ready       (request_ready_reg),
        .dout            (fifo_dout),
        .empty           (fifo_empty),
        .prog_full       (fifo_prog_full)
    );

endmodule : cu_setup

// ==== tests/tb_cu_setup.sv ====
module tb_cu_setup;
    timeunit 1ns;
    timeprecision 1ps;

    import cu_setup_cfg_pkg::*;
    import cu_setup_mem_pkg::*;

    localparam addr_t  BASE        = 32'h0001_2340;
    localparam count_t LOWER_SIZE  = 16'd40;
    localparam count_t UPPER_SIZE  = 16'd18;
    localparam int     PROG_WORDS  = LOWER_SIZE / 2;
    localparam int     TOTAL_WORDS = PROG_WORDS + UPPER_SIZE;
    localparam int     WATCHDOG    = 200 * TOTAL_WORDS + 2000;

    logic               ap_clk;
    logic               areset_cu_setup;
    kernel_descriptor_t descriptor;
    logic               cu_flush;
    mem_response_t      response;
    logic               request_ready;
    mem_request_t       request;
    logic               done_out;

    logic [31:0] lfsr = 32'h37ee;
    logic [4:0]  ready_hold = '0;
    logic [2:0]  resp_delay = '0;
    logic [2:0]  ready_hist = '0;
    logic        ready_forced_low = 1'b0;
    logic        desc_given = 1'b0;
    logic        flush_given = 1'b0;
    logic        done_seen = 1'b0;
    int          req_count = 0;
    int          resp_sent = 0;
    addr_t       pending [$];
    int          err_reset = 0;
    int          err_program = 0;
    int          err_bp = 0;
    int          err_flush = 0;
    int          err_done = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    cu_setup UUT (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .descriptor      (descriptor),
        .cu_flush        (cu_flush),
        .response        (response),
        .request_ready   (request_ready),
        .request         (request),
        .done_out        (done_out)
    );

    initial begin
        ap_clk = 1'b0;
        forever #4 ap_clk = ~ap_clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit drawn
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // Request i of a phase reads word i from base_ptr
    function automatic mem_request_payload_t expected_payload(input int idx);
        mem_request_payload_t p;
        p.cmd = CMD_MEM_READ;
        if (idx < PROG_WORDS) begin
            p.address = BASE + addr_t'(idx) * 4;
            p.kind    = BUF_PROGRAM;
        end else begin
            p.address = BASE + addr_t'(idx - PROG_WORDS) * 4;
            p.kind    = BUF_FLUSH;
        end
        return p;
    endfunction

    task automatic report_test(input string name, input int errors);
        $display("Test %s %s (%0d errors)", name, (errors == 0) ? "ok" : "failed", errors);
        if (errors == 0)
            tests_passed++;
        else
            tests_failed++;
    endtask

    // ----------------------------------------
    // Ready toggling and memory model
    // ----------------------------------------
    always @(posedge ap_clk) begin
        logic [31:0] bits;
        addr_t       addr;
        if (areset_cu_setup) begin
            request_ready <= 1'b0;
            response      <= '0;
        end else begin
            if (ready_forced_low) begin
                request_ready <= 1'b0;
            end else if (ready_hold != '0) begin
                ready_hold <= ready_hold - 5'd1;
            end else begin
                bits = random_bits(1);
                request_ready <= bits[0];
                bits = random_bits(5);
                ready_hold <= bits[4:0];
            end

            if (request.valid)
                pending.push_back(request.payload.address);
            response <= '0;
            if (resp_delay != '0) begin
                resp_delay <= resp_delay - 3'd1;
            end else if (pending.size() > 0) begin
                addr = pending.pop_front();
                response.valid <= 1'b1;
                response.data  <= addr;
                resp_sent      <= resp_sent + 1;
                bits = random_bits(3);
                resp_delay <= bits[2:0];
            end
        end
    end

    always @(posedge ap_clk) begin
        ready_hist <= {ready_hist[1:0], request_ready};
        if (areset_cu_setup)
            done_seen <= 1'b0;
        else
            done_seen <= done_seen | done_out;
        if (!areset_cu_setup && request.valid)
            req_count <= req_count + 1;
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    idle_quiet: assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
        !desc_given |-> (!request.valid && !done_out))
        else begin
            err_reset++;
            $display("ERR %0t: request or done active before any descriptor", $time);
        end

    program_order: assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
        (request.valid && req_count < PROG_WORDS) |->
            (request.payload == expected_payload(req_count)))
        else begin
            err_program++;
            $display("ERR %0t: program request %0d has wrong address or kind", $time, req_count);
        end

    flush_order: assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
        (request.valid && req_count >= PROG_WORDS) |->
            (flush_given && req_count < TOTAL_WORDS &&
             request.payload == expected_payload(req_count)))
        else begin
            err_flush++;
            $display("ERR %0t: flush request %0d early, extra or wrong", $time, req_count);
        end

    // Ready passes two registers and the FIFO read stage
    ready_respected: assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
        request.valid |-> ready_hist[2])
        else begin
            err_bp++;
            $display("ERR %0t: request left while request_ready was low", $time);
        end

    done_late: assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
        done_out |-> (req_count == TOTAL_WORDS && resp_sent == TOTAL_WORDS))
        else begin
            err_done++;
            $display("ERR %0t: done_out high with %0d responses sent", $time, resp_sent);
        end

    done_sticky: assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
        done_seen |-> done_out)
        else begin
            err_done++;
            $display("ERR %0t: done_out dropped after rising", $time);
        end

    initial begin
        repeat (WATCHDOG) @(posedge ap_clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG);
        $display("TESTS FAILED");
        $finish;
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        areset_cu_setup = 1'b1;
        descriptor      = '0;
        cu_flush        = 1'b0;
        response        = '0;
        request_ready   = 1'b0;
        repeat (5) @(posedge ap_clk);
        areset_cu_setup <= 1'b0;

        repeat (20) @(posedge ap_clk);
        report_test("reset", err_reset);

        descriptor.valid           <= 1'b1;
        descriptor.base_ptr        <= BASE;
        descriptor.size_word.upper <= UPPER_SIZE;
        descriptor.size_word.lower <= LOWER_SIZE;
        desc_given                 <= 1'b1;
        // Long stall so the FIFO fills up and the sequencer pauses
        ready_forced_low           <= 1'b1;
        @(posedge ap_clk);
        descriptor.valid <= 1'b0;
        repeat (40) @(posedge ap_clk);
        ready_forced_low <= 1'b0;

        while (req_count < PROG_WORDS) @(posedge ap_clk);
        repeat (10) @(posedge ap_clk);
        report_test("program", err_program);

        cu_flush    <= 1'b1;
        flush_given <= 1'b1;
        while (!done_out) @(posedge ap_clk);

        repeat (30) @(posedge ap_clk);
        report_test("flush", err_flush);
        assert (req_count == TOTAL_WORDS && resp_sent == TOTAL_WORDS && pending.size() == 0)
        else begin
            err_bp++;
            $display("ERR %0t: %0d requests seen, %0d expected", $time, req_count, TOTAL_WORDS);
        end
        report_test("back-pressure", err_bp);
        report_test("done", err_done);

        $display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule : tb_cu_setup

// ==== project.f ====
rtl/cu_setup_cfg_pkg.sv
rtl/cu_setup_mem_pkg.sv
rtl/cu_setup_request_fifo.sv
rtl/cu_setup_read_engine.sv
rtl/cu_setup_sequencer.sv
rtl/cu_setup.sv
tests/tb_cu_setup.sv

// ==== Bender.yml ====
package:
  name: cu_setup

sources:
  - rtl/cu_setup_cfg_pkg.sv
  - rtl/cu_setup_mem_pkg.sv
  - rtl/cu_setup_request_fifo.sv
  - rtl/cu_setup_read_engine.sv
  - rtl/cu_setup_sequencer.sv
  - rtl/cu_setup.sv
  - target: test
    files:
      - tests/tb_cu_setup.sv
